/* compile.f */
+incdir+tests
rtl/rv_isa_pkg.sv
rtl/core_pkg.sv
rtl/regfile.sv
rtl/instr_decoder.sv
rtl/alu.sv
rtl/exec_stage.sv
rtl/int_core_top.sv
tests/tb_int_core.sv

/* rtl/alu.sv */
`timescale 1ns/1ps

module alu
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  alu_op_e alu_op,
    input  xword_t  a,
    input  xword_t  b,
    output xword_t  y
);

    shamt_t shamt;
    logic   lt_signed;
    logic   lt_unsigned;

    // Shifts only look at the low five bits of operand B.
    assign shamt = b[4:0];

    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (alu_op)
            alu_add: begin
                y = a + b;
            end
            alu_sub: begin
                y = a - b;
            end
            alu_sll: begin
                y = a << shamt;
            end
            alu_slt: begin
                y = {{(xlen-1){1'b0}}, lt_signed};
            end
            alu_sltu: begin
                y = {{(xlen-1){1'b0}}, lt_unsigned};
            end
            alu_xor: begin
                y = a ^ b;
            end
            alu_srl: begin
                y = a >> shamt;
            end
            alu_sra: begin
                y = xword_t'($signed(a) >>> shamt);
            end
            alu_or: begin
                y = a | b;
            end
            alu_and: begin
                y = a & b;
            end
            alu_pass_b: begin
                y = b;
            end
            default: begin
                y = '0;
            end
        endcase
    end

endmodule

/* rtl/core_pkg.sv */
package core_pkg;

    import rv_isa_pkg::*;

    // --------------------
    // Datapath widths
    // --------------------

    localparam int xlen = 32;

    typedef logic [xlen-1:0] xword_t;
    typedef logic [4:0]      reg_addr_t;
    typedef logic [4:0]      shamt_t;

    // --------------------
    // Decoded operation
    // --------------------

    // The immediate is already sign-extended, or shifted up for LUI.
    typedef struct packed {
        logic      valid;
        logic      illegal;
        reg_addr_t rd;
        reg_addr_t rs1;
        reg_addr_t rs2;
        logic      use_imm;
        logic      use_zero_a;
        xword_t    imm;
        alu_op_e   alu_op;
    } decoded_op_t;

    // --------------------
    // Writeback request
    // --------------------

    // Also serves as the register file write port.
    typedef struct packed {
        logic      valid;
        reg_addr_t rd;
        xword_t    data;
    } wb_req_t;

endpackage

/* rtl/exec_stage.sv */
`timescale 1ns/1ps

module exec_stage
    import core_pkg::*;
(
    input  logic        clk,
    input  logic        rst_n,

    input  decoded_op_t op,
    input  xword_t      rs1_data,
    input  xword_t      rs2_data,

    output wb_req_t     wb,
    output logic        illegal
);

    xword_t opnd_a;
    xword_t opnd_b;
    xword_t result;

    // --------------------
    // Operand select
    // --------------------

    // LUI adds nothing to its immediate, so A is forced to zero.
    assign opnd_a = op.use_zero_a ? '0 : rs1_data;
    assign opnd_b = op.use_imm ? op.imm : rs2_data;

    alu alu_i (
        .alu_op (op.alu_op),
        .a      (opnd_a),
        .b      (opnd_b),
        .y      (result)
    );

    // --------------------
    // Writeback register
    // --------------------

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb      <= '0;
            illegal <= 1'b0;
        end else begin
            wb.valid <= op.valid && !op.illegal;
            wb.rd    <= op.rd;
            wb.data  <= result;
            illegal  <= op.valid && op.illegal;
        end
    end

endmodule

/* rtl/instr_decoder.sv */
`timescale 1ns/1ps

module instr_decoder
    import rv_isa_pkg::*;
    import core_pkg::*;
(
    input  logic        instr_valid,
    input  xword_t      instr,
    output decoded_op_t op
);

    opcode_t   opcode;
    funct3_t   funct3;
    funct7_t   funct7;
    reg_addr_t rd_field;
    reg_addr_t rs1_field;
    reg_addr_t rs2_field;
    xword_t    imm_i;
    xword_t    imm_u;

    logic      legal;
    logic      use_imm;
    logic      zero_a;
    xword_t    imm;
    alu_op_e   alu_op;

    // --------------------
    // Field extraction
    // --------------------

    assign opcode    = instr[opc_lsb +: $bits(opcode_t)];
    assign funct3    = instr[f3_lsb +: $bits(funct3_t)];
    assign funct7    = instr[f7_lsb +: $bits(funct7_t)];
    assign rd_field  = instr[rd_lsb +: $bits(reg_addr_t)];
    assign rs1_field = instr[rs1_lsb +: $bits(reg_addr_t)];
    assign rs2_field = instr[rs2_lsb +: $bits(reg_addr_t)];

    assign imm_i = {{(xlen-12){instr[xlen-1]}}, instr[imm_i_lsb +: 12]};
    assign imm_u = {instr[imm_u_lsb +: 20], 12'b0};

    // Operation implied by funct3 alone, before funct7 picks SUB or SRA.
    function automatic alu_op_e base_alu_op(input funct3_t f3);
        alu_op_e result;

        case (f3)
            f3_sll:  result = alu_sll;
            f3_slt:  result = alu_slt;
            f3_sltu: result = alu_sltu;
            f3_xor:  result = alu_xor;
            f3_sr:   result = alu_srl;
            f3_or:   result = alu_or;
            f3_and:  result = alu_and;
            default: result = alu_add;
        endcase
        return result;
    endfunction

    // --------------------
    // Opcode decode
    // --------------------

    always_comb begin
        legal   = 1'b0;
        use_imm = 1'b0;
        zero_a  = 1'b0;
        imm     = imm_i;
        alu_op  = base_alu_op(funct3);

        case (opcode)
            opc_op: begin
                if (funct7 == f7_base) begin
                    legal = 1'b1;
                end else if (funct7 == f7_alt && (funct3 == f3_add || funct3 == f3_sr)) begin
                    legal  = 1'b1;
                    alu_op = (funct3 == f3_add) ? alu_sub : alu_sra;
                end
            end
            opc_op_imm: begin
                use_imm = 1'b1;
                // Shift immediates carry funct7 in the upper immediate bits.
                if (funct3 == f3_sll) begin
                    legal = (funct7 == f7_base);
                end else if (funct3 == f3_sr) begin
                    legal = (funct7 == f7_base) || (funct7 == f7_alt);
                    if (funct7 == f7_alt) begin
                        alu_op = alu_sra;
                    end
                end else begin
                    legal = 1'b1;
                end
            end
            opc_lui: begin
                legal   = 1'b1;
                use_imm = 1'b1;
                zero_a  = 1'b1;
                imm     = imm_u;
                alu_op  = alu_pass_b;
            end
            default: begin
                legal = 1'b0;
            end
        endcase
    end

    // An illegal instruction keeps rd at x0 so nothing can be written.
    always_comb begin
        op            = '0;
        op.valid      = instr_valid;
        op.illegal    = !legal;
        op.rd         = legal ? rd_field : '0;
        op.rs1        = rs1_field;
        op.rs2        = rs2_field;
        op.use_imm    = use_imm;
        op.use_zero_a = zero_a;
        op.imm        = imm;
        op.alu_op     = alu_op;
    end

endmodule

/* rtl/int_core_top.sv */
`timescale 1ns/1ps

module int_core_top
    import core_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    instr_valid,
    input  xword_t  instr,

    output wb_req_t wb,
    output logic    illegal
);

    decoded_op_t dec_op;
    xword_t      rs1_data;
    xword_t      rs2_data;

    instr_decoder instr_decoder_i (
        .instr_valid (instr_valid),
        .instr       (instr),
        .op          (dec_op)
    );

    // The registered writeback doubles as the write port, which gives
    // the bypass path for back-to-back dependent instructions.
    regfile regfile_i (
        .clk    (clk),
        .rst_n  (rst_n),
        .wr     (wb),
        .raddr1 (dec_op.rs1),
        .raddr2 (dec_op.rs2),
        .rdata1 (rs1_data),
        .rdata2 (rs2_data)
    );

    exec_stage exec_stage_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .op       (dec_op),
        .rs1_data (rs1_data),
        .rs2_data (rs2_data),
        .wb       (wb),
        .illegal  (illegal)
    );

endmodule

/* rtl/regfile.sv */
`timescale 1ns/1ps

module regfile
    import core_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,

    input  wb_req_t   wr,

    input  reg_addr_t raddr1,
    input  reg_addr_t raddr2,
    output xword_t    rdata1,
    output xword_t    rdata2
);

    xword_t regs [32];

    // --------------------
    // Write port
    // --------------------

    // x0 is never written, so its entry stays at the reset value.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.valid && wr.rd != '0) begin
            regs[wr.rd] <= wr.data;
        end
    end

    // --------------------
    // Read ports
    // --------------------

    // Zero register first, then the same-cycle bypass, then the array.
    function automatic xword_t read_mux(
        input reg_addr_t addr,
        input xword_t    stored,
        input wb_req_t   w
    );
        xword_t result;

        if (addr == '0) begin
            result = '0;
        end else if (w.valid && w.rd == addr) begin
            result = w.data;
        end else begin
            result = stored;
        end
        return result;
    endfunction

    always_comb begin
        rdata1 = read_mux(raddr1, regs[raddr1], wr);
    end

    always_comb begin
        rdata2 = read_mux(raddr2, regs[raddr2], wr);
    end

endmodule

/* rtl/rv_isa_pkg.sv */
package rv_isa_pkg;

    // --------------------
    // Field types
    // --------------------

    typedef logic [6:0] opcode_t;
    typedef logic [2:0] funct3_t;
    typedef logic [6:0] funct7_t;

    // Bit positions of the instruction fields.
    localparam int opc_lsb   = 0;
    localparam int rd_lsb    = 7;
    localparam int f3_lsb    = 12;
    localparam int rs1_lsb   = 15;
    localparam int rs2_lsb   = 20;
    localparam int f7_lsb    = 25;
    localparam int imm_i_lsb = 20;
    localparam int imm_u_lsb = 12;

    // --------------------
    // Major opcodes
    // --------------------

    localparam opcode_t opc_op     = 7'b0110011;
    localparam opcode_t opc_op_imm = 7'b0010011;
    localparam opcode_t opc_lui    = 7'b0110111;

    // --------------------
    // Function codes
    // --------------------

    localparam funct3_t f3_add  = 3'b000;
    localparam funct3_t f3_sll  = 3'b001;
    localparam funct3_t f3_slt  = 3'b010;
    localparam funct3_t f3_sltu = 3'b011;
    localparam funct3_t f3_xor  = 3'b100;
    localparam funct3_t f3_sr   = 3'b101;
    localparam funct3_t f3_or   = 3'b110;
    localparam funct3_t f3_and  = 3'b111;

    // The alternate funct7 selects SUB and SRA.
    localparam funct7_t f7_base = 7'b0000000;
    localparam funct7_t f7_alt  = 7'b0100000;

    // --------------------
    // ALU operations
    // --------------------

    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        alu_pass_b = 4'd10
    } alu_op_e;

endpackage

/* tests/tb_int_core_tasks.svh */
// --------------------
// Instruction encoders
// --------------------

function automatic xword_t r_type(input funct7_t f7, input funct3_t f3,
                                  input reg_addr_t rd, input reg_addr_t rs1, input reg_addr_t rs2);
    return {f7, rs2, rs1, f3, rd, opc_op};
endfunction

function automatic xword_t i_type(input funct3_t f3, input reg_addr_t rd,
                                  input reg_addr_t rs1, input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc_op_imm};
endfunction

function automatic xword_t lui_word(input reg_addr_t rd, input logic [19:0] imm);
    return {imm, rd, opc_lui};
endfunction

function automatic reg_addr_t pick_reg();
    reg_addr_t r;

    r = reg_addr_t'(lfsr_bits(5));
    return (r == '0) ? reg_addr_t'(1) : r;
endfunction

// --------------------
// Directed tests
// --------------------

task automatic reset_values();
    checks++;
    assert (!wb.valid && !illegal) else begin
        errors++;
        $display("** Error @ %0t: writeback or illegal active after reset", $time);
    end
    for (int n = 0; n < 32; n++) begin
        issue(r_type(f7_base, f3_add, pick_reg(), reg_addr_t'(n), '0));
    end
endtask

task automatic arith_ops();
    funct3_t     f3;
    logic [11:0] imm;
    logic        alt;

    // Immediate forms and LUI spread values, then every R-type operation.
    for (int n = 0; n < 24; n++) begin
        f3  = funct3_t'(n % 10);
        imm = 12'(lfsr_bits(12));
        alt = ((n / 10) % 2) == 1;
        if (n % 10 >= 8) begin
            issue(lui_word(pick_reg(), 20'(lfsr_bits(20))));
        end else begin
            if (f3 == f3_sll || f3 == f3_sr) begin
                imm[11:5] = (f3 == f3_sr && alt) ? f7_alt : f7_base;
            end
            issue(i_type(f3, pick_reg(), reg_addr_t'(lfsr_bits(5)), imm));
        end
    end
    for (int n = 0; n < 24; n++) begin
        f3  = funct3_t'(n % 8);
        alt = (n / 8 == 1) && (f3 == f3_add || f3 == f3_sr);
        issue(r_type(alt ? f7_alt : f7_base, f3, pick_reg(),
                     reg_addr_t'(lfsr_bits(5)), reg_addr_t'(lfsr_bits(5))));
    end
endtask

task automatic zero_register();
    issue(i_type(f3_add, '0, pick_reg(), 12'h123));
    issue(r_type(f7_base, f3_or, pick_reg(), '0, '0));
    issue(lui_word('0, 20'hfffff));
    issue(i_type(f3_xor, pick_reg(), '0, 12'h0ff));
    issue(r_type(f7_alt, f3_add, pick_reg(), '0, pick_reg()));
    issue(r_type(f7_base, f3_add, pick_reg(), '0, '0));
endtask

// Each instruction reads the register written by the one just before it.
task automatic dependent_chain();
    reg_addr_t prev;
    reg_addr_t rd;
    funct3_t   f3;
    logic      alt;

    prev = pick_reg();
    issue(lui_word(prev, 20'(lfsr_bits(20))));
    for (int n = 0; n < 16; n++) begin
        rd   = pick_reg();
        f3   = funct3_t'(n % 8);
        alt  = (n >= 8) && (f3 == f3_add || f3 == f3_sr);
        issue(r_type(alt ? f7_alt : f7_base, f3, rd, prev, (n % 3 == 0) ? prev : pick_reg()));
        prev = rd;
    end
endtask

task automatic illegal_encodings();
    reg_addr_t rd;
    xword_t    ins;

    for (int n = 0; n < 6; n++) begin
        rd  = pick_reg();
        ins = lfsr_bits(32);
        case (n)
            0: ins[6:0] = 7'b0000011;
            1: ins[6:0] = 7'b1100011;
            2: ins = r_type(7'b0000001, f3_add, rd, pick_reg(), pick_reg());
            3: ins = r_type(f7_alt, f3_xor, rd, pick_reg(), pick_reg());
            4: ins = i_type(f3_sll, rd, pick_reg(), {f7_alt, 5'd3});
            default: ins = i_type(f3_sr, rd, pick_reg(), {7'b0000001, 5'd7});
        endcase
        ins[11:7] = rd;
        issue(ins);
        // Reading the destination back shows it was left alone.
        issue(r_type(f7_base, f3_or, rd, rd, '0));
    end
endtask

/* tests/tb_int_core.sv */
`timescale 1ns/1ps

module tb_int_core
    import rv_isa_pkg::*;
    import core_pkg::*;
();

    // Instructions issued by the five tests together.
    localparam int total_instr = 32 + 48 + 6 + 17 + 12;
    localparam int timeout_ns  = 2 * (total_instr + 20) * 20;

    logic    clk;
    logic    rst_n;
    logic    instr_valid;
    xword_t  instr;
    wb_req_t wb;
    logic    illegal;

    xword_t      ref_regs [32];
    logic [31:0] lfsr;
    logic        pend;
    wb_req_t     exp_wb;
    logic        exp_ill;
    int          checks;
    int          errors;

    int_core_top dut_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .instr_valid (instr_valid),
        .instr       (instr),
        .wb          (wb),
        .illegal     (illegal)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // Fibonacci LFSR with taps 32, 22, 2 and 1, stepped once per bit taken.
    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;

        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            v    = {v[30:0], lfsr[0]};
        end
        return v;
    endfunction

    // --------------------
    // Reference model
    // --------------------

    function automatic xword_t ref_alu(input funct3_t f3, input logic alt,
                                       input xword_t a, input xword_t b);
        xword_t y;

        case (f3)
            f3_add:  y = alt ? a - b : a + b;
            f3_sll:  y = a << b[4:0];
            f3_slt:  y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            f3_sltu: y = (a < b) ? 32'd1 : 32'd0;
            f3_xor:  y = a ^ b;
            f3_or:   y = a | b;
            f3_and:  y = a & b;
            default: begin
                if (alt) begin
                    y = xword_t'($signed(a) >>> b[4:0]);
                end else begin
                    y = a >> b[4:0];
                end
            end
        endcase
        return y;
    endfunction

    // Expected writeback of one instruction; the model registers are updated too.
    function automatic wb_req_t model_exec(input xword_t ins, output logic ill);
        wb_req_t r;
        funct3_t f3;
        funct7_t f7;
        logic    shift;

        r     = '0;
        f3    = ins[14:12];
        f7    = ins[31:25];
        shift = (f3 == f3_sll) || (f3 == f3_sr);
        r.rd  = ins[11:7];
        ill   = 1'b0;
        case (ins[6:0])
            opc_lui: r.data = {ins[31:12], 12'h000};
            opc_op: begin
                ill = !(f7 == f7_base || (f7 == f7_alt && (f3 == f3_add || f3 == f3_sr)));
                r.data = ref_alu(f3, f7 == f7_alt, ref_regs[ins[19:15]], ref_regs[ins[24:20]]);
            end
            opc_op_imm: begin
                ill = shift && !(f7 == f7_base || (f7 == f7_alt && f3 == f3_sr));
                r.data = ref_alu(f3, shift && f7 == f7_alt, ref_regs[ins[19:15]],
                                 {{20{ins[31]}}, ins[31:20]});
            end
            default: ill = 1'b1;
        endcase
        r.valid = !ill;
        if (r.valid && r.rd != '0) begin
            ref_regs[r.rd] = r.data;
        end
        return r;
    endfunction

    // --------------------
    // Issue and check
    // --------------------

    task automatic check_wb();
        if (pend) begin
            checks++;
            assert (wb.valid == exp_wb.valid && illegal == exp_ill) else begin
                errors++;
                $display("** Error @ %0t: valid %b illegal %b, expected valid %b illegal %b",
                         $time, wb.valid, illegal, exp_wb.valid, exp_ill);
            end
            if (exp_wb.valid) begin
                assert (wb.rd == exp_wb.rd && wb.data == exp_wb.data) else begin
                    errors++;
                    $display("** Error @ %0t: x%0d = %h, expected x%0d = %h",
                             $time, wb.rd, wb.data, exp_wb.rd, exp_wb.data);
                end
            end
        end
    endtask

    // The result of the previous instruction is checked before the next is driven.
    task automatic issue(input xword_t ins);
        logic ill;

        @(negedge clk);
        check_wb();
        instr_valid = 1'b1;
        instr       = ins;
        exp_wb      = model_exec(ins, ill);
        exp_ill     = ill;
        pend        = 1'b1;
    endtask

    task automatic idle();
        @(negedge clk);
        check_wb();
        instr_valid = 1'b0;
        instr       = lfsr_bits(32);
        exp_wb      = '0;
        exp_ill     = 1'b0;
        pend        = 1'b1;
    endtask

    `include "tb_int_core_tasks.svh"

    initial begin
        rst_n       = 1'b0;
        instr_valid = 1'b0;
        instr       = '0;
        lfsr        = 32'ha9428726;
        pend        = 1'b0;
        exp_wb      = '0;
        exp_ill     = 1'b0;
        checks      = 0;
        errors      = 0;
        for (int i = 0; i < 32; i++) begin
            ref_regs[i] = '0;
        end
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        reset_values();
        arith_ops();
        zero_register();
        dependent_chain();
        illegal_encodings();
        idle();
        idle();

        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

    initial begin
        #(timeout_ns);
        $display("Timeout: the tests did not finish within %0d ns.", timeout_ns);
        $display("=== FAIL ===");
        $finish;
    end

endmodule
